//--- hdl/axi_pkg.sv
/*
  AXI channel types shared by the bridge masters.
  32-bit address and data, 4-bit IDs, AXI3-style 4-bit burst length.
  Valid and ready are never part of a payload struct.
*/
`default_nettype none

package axi_pkg;

  typedef logic [3:0]  id_t;
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [3:0]  len_t;
  typedef logic [2:0]  size_t;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  // 4 bytes per beat
  localparam size_t SIZE_WORD = 3'b010;

  // ================================================
  // channel payloads
  // ================================================
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_e burst;
  } ar_t;

  typedef ar_t aw_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_e resp;
    logic  last;
  } r_t;

  typedef struct packed {
    id_t   id;
    resp_e resp;
  } b_t;

endpackage

`default_nettype wire

//--- hdl/mem_req_pkg.sv
/*
  Cache-side request types.
  Access codes follow the RISC-V load/store funct3 values.
  Unsigned codes only matter to the requester; writes treat them as signed.
*/
`default_nettype none

package mem_req_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // ================================================
  // access width of one request
  // ================================================
  typedef enum logic [2:0] {
    BYTE   = 3'b000,
    HALF   = 3'b001,
    WORD   = 3'b010,
    BYTE_U = 3'b100,
    HALF_U = 3'b101
  } access_e;

  // one request from the data-side cache
  typedef struct packed {
    addr_t   addr;
    data_t   wdata;
    access_e access;
    logic    write;
  } mem_req_t;

endpackage

`default_nettype wire

//--- hdl/axi_read_master.sv
/*
  Single-outstanding AXI read master, one INCR word burst per request.
  req is a one-cycle pulse and may only come while busy is low.
  rdata follows R in the beat cycle and holds the last beat afterwards.
  Burst length is fixed by BURST_BEATS (1 to 16).
*/
`timescale 1ns/10ps
`default_nettype none

module axi_read_master #(
  parameter axi_pkg::id_t READ_ID     = '0,
  parameter int           BURST_BEATS = 4
) (
  input  wire logic           ACLK,
  input  wire logic           ARESETn,
  input  wire logic           req,
  input  wire axi_pkg::addr_t addr,
  input  wire logic           ar_ready,
  input  wire axi_pkg::r_t    r,
  input  wire logic           r_valid,
  output logic                busy,
  output axi_pkg::data_t      rdata,
  output logic                beat_valid,
  output axi_pkg::ar_t        ar,
  output logic                ar_valid,
  output logic                r_ready
);

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    DATA
  } state_e;

  state_e         state;
  state_e         state_nxt;
  axi_pkg::ar_t   ar_new;
  axi_pkg::ar_t   ar_q;
  axi_pkg::data_t rdata_q;
  logic           r_hs;

  assign r_hs = r_valid & r_ready;

  // burst descriptor built from the live request address
  assign ar_new = '{
    id:    READ_ID,
    addr:  addr,
    len:   axi_pkg::len_t'(BURST_BEATS - 1),
    size:  axi_pkg::SIZE_WORD,
    burst: axi_pkg::INCR
  };

  // ================================================
  // state machine
  // ================================================
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (req) begin
          state_nxt = ar_ready ? DATA : ADDR;
        end
      end
      ADDR: begin
        if (ar_ready) begin
          state_nxt = DATA;
        end
      end
      DATA: begin
        if (r_hs && r.last) begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // descriptor held while AR waits, last beat held for the requester
  always_ff @(posedge ACLK) begin
    if (state == IDLE && req) begin
      ar_q <= ar_new;
    end
    if (r_hs) begin
      rdata_q <= r.data;
    end
  end

  // ================================================
  // outputs
  // ================================================
  // request cycle drives AR straight from the input
  assign ar         = (state == IDLE) ? ar_new : ar_q;
  assign ar_valid   = (state == IDLE) ? req : (state == ADDR);
  assign r_ready    = (state == DATA);
  assign busy       = req | (state != IDLE);
  assign beat_valid = r_hs;
  assign rdata      = r_hs ? r.data : rdata_q;

endmodule

`default_nettype wire

//--- hdl/axi_write_master.sv
/*
  Single-beat AXI write master with byte strobes from the access type.
  AW and W are raised together in the request cycle, each held to its
  own handshake; B is accepted only after both have gone.
  Address is passed unaligned, the slave uses the strobes.
*/
`timescale 1ns/10ps
`default_nettype none

module axi_write_master #(
  parameter axi_pkg::id_t WRITE_ID = 4'd1
) (
  input  wire logic                  ACLK,
  input  wire logic                  ARESETn,
  input  wire logic                  req,
  input  wire mem_req_pkg::mem_req_t cmd,
  input  wire logic                  aw_ready,
  input  wire logic                  w_ready,
  input  wire axi_pkg::b_t           b,
  input  wire logic                  b_valid,
  output logic                       busy,
  output axi_pkg::aw_t               aw,
  output logic                       aw_valid,
  output axi_pkg::w_t                w,
  output logic                       w_valid,
  output logic                       b_ready
);

  typedef enum logic [1:0] {
    IDLE,
    SEND,
    RESP
  } state_e;

  state_e       state;
  state_e       state_nxt;
  axi_pkg::aw_t aw_new;
  axi_pkg::aw_t aw_q;
  axi_pkg::w_t  w_new;
  axi_pkg::w_t  w_q;
  logic         aw_done;
  logic         w_done;
  logic         aw_fin;
  logic         w_fin;
  logic         b_hs;

  // byte lanes touched by one store
  function automatic axi_pkg::strb_t byte_strobe(
    input mem_req_pkg::access_e access,
    input logic [1:0]           offset
  );
    axi_pkg::strb_t strb;
    case (access)
      mem_req_pkg::BYTE,
      mem_req_pkg::BYTE_U: strb = 4'b0001 << offset;
      mem_req_pkg::HALF,
      mem_req_pkg::HALF_U: strb = 4'b0011 << offset;
      default:             strb = 4'b1111;
    endcase
    return strb;
  endfunction

  assign aw_new = '{
    id:    WRITE_ID,
    addr:  cmd.addr,
    len:   '0,
    size:  axi_pkg::SIZE_WORD,
    burst: axi_pkg::INCR
  };

  assign w_new = '{
    data: cmd.wdata,
    strb: byte_strobe(cmd.access, cmd.addr[1:0]),
    last: 1'b1
  };

  // a channel is finished once it has handshaken, now or earlier
  assign aw_fin = aw_done | (aw_valid & aw_ready);
  assign w_fin  = w_done | (w_valid & w_ready);
  assign b_hs   = b_valid & b_ready;

  // ================================================
  // state machine
  // ================================================
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (req) begin
          state_nxt = (aw_fin && w_fin) ? RESP : SEND;
        end
      end
      SEND: begin
        if (aw_fin && w_fin) begin
          state_nxt = RESP;
        end
      end
      RESP: begin
        if (b_hs) begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state   <= IDLE;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      state <= state_nxt;
      // flags only live while still sending
      aw_done <= (state_nxt == SEND) & aw_fin;
      w_done  <= (state_nxt == SEND) & w_fin;
    end
  end

  always_ff @(posedge ACLK) begin
    if (state == IDLE && req) begin
      aw_q <= aw_new;
      w_q  <= w_new;
    end
  end

  // ================================================
  // outputs
  // ================================================
  assign aw       = (state == IDLE) ? aw_new : aw_q;
  assign w        = (state == IDLE) ? w_new : w_q;
  assign aw_valid = (state == IDLE) ? req : (state == SEND) & ~aw_done;
  assign w_valid  = (state == IDLE) ? req : (state == SEND) & ~w_done;
  assign b_ready  = (state == RESP);
  assign busy     = req | (state != IDLE);

endmodule

`default_nettype wire

//--- hdl/data_port_ctrl.sv
/*
  Data-side port: reads go to a burst read master, writes to a
  single-beat write master, both on AXI master 1.
  Busy is shared, so one transaction at a time on this port.
*/
`timescale 1ns/10ps
`default_nettype none

module data_port_ctrl #(
  parameter axi_pkg::id_t READ_ID     = '0,
  parameter axi_pkg::id_t WRITE_ID    = 4'd1,
  parameter int           BURST_BEATS = 4
) (
  input  wire logic                  ACLK,
  input  wire logic                  ARESETn,
  input  wire logic                  d_req,
  input  wire mem_req_pkg::mem_req_t d_cmd,
  output logic                       d_busy,
  output axi_pkg::data_t             d_rdata,
  output logic                       d_beat_valid,
  output axi_pkg::ar_t               m1_ar,
  output logic                       m1_ar_valid,
  input  wire logic                  m1_ar_ready,
  input  wire axi_pkg::r_t           m1_r,
  input  wire logic                  m1_r_valid,
  output logic                       m1_r_ready,
  output axi_pkg::aw_t               m1_aw,
  output logic                       m1_aw_valid,
  input  wire logic                  m1_aw_ready,
  output axi_pkg::w_t                m1_w,
  output logic                       m1_w_valid,
  input  wire logic                  m1_w_ready,
  input  wire axi_pkg::b_t           m1_b,
  input  wire logic                  m1_b_valid,
  output logic                       m1_b_ready
);

  logic rd_req;
  logic wr_req;
  logic rd_busy;
  logic wr_busy;

  // steer by direction
  assign rd_req = d_req & ~d_cmd.write;
  assign wr_req = d_req & d_cmd.write;
  assign d_busy = rd_busy | wr_busy;

  axi_read_master #(
    .READ_ID     (READ_ID),
    .BURST_BEATS (BURST_BEATS)
  ) rd_master_i (
    .ACLK       (ACLK),
    .ARESETn    (ARESETn),
    .req        (rd_req),
    .addr       (d_cmd.addr),
    .ar_ready   (m1_ar_ready),
    .r          (m1_r),
    .r_valid    (m1_r_valid),
    .busy       (rd_busy),
    .rdata      (d_rdata),
    .beat_valid (d_beat_valid),
    .ar         (m1_ar),
    .ar_valid   (m1_ar_valid),
    .r_ready    (m1_r_ready)
  );

  axi_write_master #(
    .WRITE_ID (WRITE_ID)
  ) wr_master_i (
    .ACLK     (ACLK),
    .ARESETn  (ARESETn),
    .req      (wr_req),
    .cmd      (d_cmd),
    .aw_ready (m1_aw_ready),
    .w_ready  (m1_w_ready),
    .b        (m1_b),
    .b_valid  (m1_b_valid),
    .busy     (wr_busy),
    .aw       (m1_aw),
    .aw_valid (m1_aw_valid),
    .w        (m1_w),
    .w_valid  (m1_w_valid),
    .b_ready  (m1_b_ready)
  );

endmodule

`default_nettype wire

//--- hdl/cpu_bridge.sv
/*
  Cache-to-AXI bridge top level.
  Master 0 serves instruction fetch bursts, master 1 the data port.
  The two ports run independently, each with one transaction in flight.
*/
`timescale 1ns/10ps
`default_nettype none

module cpu_bridge #(
  parameter axi_pkg::id_t READ_ID     = 4'd0,
  parameter axi_pkg::id_t WRITE_ID    = 4'd1,
  parameter int           BURST_BEATS = 4
) (
  input  wire logic                  ACLK,
  input  wire logic                  ARESETn,
  // instruction side
  input  wire logic                  i_req,
  input  wire mem_req_pkg::addr_t    i_addr,
  output logic                       i_busy,
  output axi_pkg::data_t             i_rdata,
  output logic                       i_beat_valid,
  // data side
  input  wire logic                  d_req,
  input  wire mem_req_pkg::mem_req_t d_cmd,
  output logic                       d_busy,
  output axi_pkg::data_t             d_rdata,
  output logic                       d_beat_valid,
  // ================================================
  // AXI master 0, read only
  // ================================================
  output axi_pkg::ar_t               m0_ar,
  output logic                       m0_ar_valid,
  input  wire logic                  m0_ar_ready,
  input  wire axi_pkg::r_t           m0_r,
  input  wire logic                  m0_r_valid,
  output logic                       m0_r_ready,
  // ================================================
  // AXI master 1
  // ================================================
  output axi_pkg::ar_t               m1_ar,
  output logic                       m1_ar_valid,
  input  wire logic                  m1_ar_ready,
  input  wire axi_pkg::r_t           m1_r,
  input  wire logic                  m1_r_valid,
  output logic                       m1_r_ready,
  output axi_pkg::aw_t               m1_aw,
  output logic                       m1_aw_valid,
  input  wire logic                  m1_aw_ready,
  output axi_pkg::w_t                m1_w,
  output logic                       m1_w_valid,
  input  wire logic                  m1_w_ready,
  input  wire axi_pkg::b_t           m1_b,
  input  wire logic                  m1_b_valid,
  output logic                       m1_b_ready
);

  // instruction fetch, line-sized bursts
  axi_read_master #(
    .READ_ID     (READ_ID),
    .BURST_BEATS (BURST_BEATS)
  ) inst_port_i (
    .ACLK       (ACLK),
    .ARESETn    (ARESETn),
    .req        (i_req),
    .addr       (i_addr),
    .ar_ready   (m0_ar_ready),
    .r          (m0_r),
    .r_valid    (m0_r_valid),
    .busy       (i_busy),
    .rdata      (i_rdata),
    .beat_valid (i_beat_valid),
    .ar         (m0_ar),
    .ar_valid   (m0_ar_valid),
    .r_ready    (m0_r_ready)
  );

  data_port_ctrl #(
    .READ_ID     (READ_ID),
    .WRITE_ID    (WRITE_ID),
    .BURST_BEATS (BURST_BEATS)
  ) data_port_i (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .d_req        (d_req),
    .d_cmd        (d_cmd),
    .d_busy       (d_busy),
    .d_rdata      (d_rdata),
    .d_beat_valid (d_beat_valid),
    .m1_ar        (m1_ar),
    .m1_ar_valid  (m1_ar_valid),
    .m1_ar_ready  (m1_ar_ready),
    .m1_r         (m1_r),
    .m1_r_valid   (m1_r_valid),
    .m1_r_ready   (m1_r_ready),
    .m1_aw        (m1_aw),
    .m1_aw_valid  (m1_aw_valid),
    .m1_aw_ready  (m1_aw_ready),
    .m1_w         (m1_w),
    .m1_w_valid   (m1_w_valid),
    .m1_w_ready   (m1_w_ready),
    .m1_b         (m1_b),
    .m1_b_valid   (m1_b_valid),
    .m1_b_ready   (m1_b_ready)
  );

endmodule

`default_nettype wire

//--- testbench/tb_cpu_bridge.sv
/*
  Testbench for cpu_bridge with an AXI slave memory model on both masters.
  Replays testbench/cpu_bridge_trace.txt, so it must run from the project root.
  Memory word at address A starts as A ^ 32'hA5A5_0000.
  Instruction and data requests on one trace line must not touch the same words.
*/
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_bridge;

  localparam int          BEATS      = 4;
  localparam logic [31:0] FILL_KEY   = 32'hA5A5_0000;
  localparam string       TRACE_PATH = "testbench/cpu_bridge_trace.txt";

  // one trace line
  typedef struct packed {
    logic [1:0]  ports;
    logic [31:0] i_addr;
    logic        write;
    logic [2:0]  access;
    logic [31:0] d_addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
  } trace_t;

  logic                  ACLK = 1'b0;
  logic                  ARESETn;
  logic                  i_req;
  mem_req_pkg::addr_t    i_addr;
  logic                  i_busy;
  axi_pkg::data_t        i_rdata;
  logic                  i_beat_valid;
  logic                  d_req;
  mem_req_pkg::mem_req_t d_cmd;
  logic                  d_busy;
  axi_pkg::data_t        d_rdata;
  logic                  d_beat_valid;
  axi_pkg::ar_t          m0_ar;
  logic                  m0_ar_valid;
  logic                  m0_ar_ready;
  axi_pkg::r_t           m0_r;
  logic                  m0_r_valid;
  logic                  m0_r_ready;
  axi_pkg::ar_t          m1_ar;
  logic                  m1_ar_valid;
  logic                  m1_ar_ready;
  axi_pkg::r_t           m1_r;
  logic                  m1_r_valid;
  logic                  m1_r_ready;
  axi_pkg::aw_t          m1_aw;
  logic                  m1_aw_valid;
  logic                  m1_aw_ready;
  axi_pkg::w_t           m1_w;
  logic                  m1_w_valid;
  logic                  m1_w_ready;
  axi_pkg::b_t           m1_b;
  logic                  m1_b_valid;
  logic                  m1_b_ready;

  trace_t      trace_q[$];
  trace_t      cur;
  logic [31:0] slave_mem[logic [31:0]];
  logic [31:0] ref_mem[logic [31:0]];
  // slave model and checker state updated at the rising edge
  logic        rd_on[2]     = '{1'b0, 1'b0};
  logic [31:0] rd_base[2]   = '{32'd0, 32'd0};
  int          rd_beat[2]   = '{0, 0};
  logic        held_on[4]   = '{default: 1'b0};
  logic [44:0] held_val[4]  = '{default: '0};
  logic        aw_got       = 1'b0;
  logic        w_got        = 1'b0;
  logic        b_pend       = 1'b0;
  logic        wr_open      = 1'b0;
  logic        wr_end       = 1'b0;
  logic [31:0] aw_addr      = '0;
  logic [31:0] w_data       = '0;
  logic [3:0]  w_strb       = '0;
  logic [31:0] i_hold       = '0;
  logic [31:0] d_hold       = '0;
  logic        i_end        = 1'b0;
  logic        d_end        = 1'b0;
  int          i_count      = 0;
  int          d_count      = 0;
  int          mismatches   = 0;
  int          failures     = 0;
  int          seq_errors   = 0;
  int          cycles       = 0;
  int          cycle_limit  = 200;
  integer      seed         = 55089;

  cpu_bridge #(
    .READ_ID     (4'd0),
    .WRITE_ID    (4'd1),
    .BURST_BEATS (BEATS)
  ) dut_i (.*);

  always #50 ACLK = ~ACLK;

  // ================================================
  // memory helpers
  // ================================================
  function automatic logic [31:0] slave_word(input logic [31:0] a);
    logic [31:0] wa;
    wa = {a[31:2], 2'b00};
    return slave_mem.exists(wa) ? slave_mem[wa] : (wa ^ FILL_KEY);
  endfunction

  function automatic logic [31:0] ref_word(input logic [31:0] a);
    logic [31:0] wa;
    wa = {a[31:2], 2'b00};
    return ref_mem.exists(wa) ? ref_mem[wa] : (wa ^ FILL_KEY);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                              input logic [31:0] data,
                                              input logic [3:0]  strb);
    logic [31:0] word;
    word = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        word[8*b +: 8] = data[8*b +: 8];
      end
    end
    return word;
  endfunction

  // roughly three quarters of draws say ready
  function automatic logic ready_draw();
    return ($random(seed) & 3) != 0;
  endfunction

  function automatic axi_pkg::r_t read_beat(input int m);
    axi_pkg::r_t r;
    r.id   = 4'd0;
    r.data = slave_word(rd_base[m] + 32'(rd_beat[m] * 4));
    r.resp = axi_pkg::OKAY;
    r.last = (rd_beat[m] == BEATS - 1);
    return r;
  endfunction

  function automatic axi_pkg::ar_t expect_ar(input logic [3:0] id, input logic [31:0] a,
                                             input logic [3:0] len);
    axi_pkg::ar_t d;
    d.id    = id;
    d.addr  = a;
    d.len   = len;
    d.size  = 3'b010;
    d.burst = axi_pkg::INCR;
    return d;
  endfunction

  // ================================================
  // checks sampled at the rising edge
  // ================================================
  task automatic check_beats();
    if ((i_req && !i_busy) || (d_req && !d_busy)) begin
      failures++;
      $display("busy was low in a request cycle at time %0t", $time);
    end
    if (i_end && i_busy && !i_req) begin
      mismatches++;
      $display("mismatch at time %0t: i_busy still high after the last beat", $time);
    end
    if (d_end && d_busy && !d_req) begin
      mismatches++;
      $display("mismatch at time %0t: d_busy still high after the last beat", $time);
    end
    if (i_req) begin
      i_count = 0;
    end
    if (d_req) begin
      d_count = 0;
    end
    if (i_beat_valid) begin
      i_hold = ref_word(cur.i_addr + 32'(i_count * 4));
      if (i_count >= BEATS) begin
        failures++;
        $display("extra instruction beat at time %0t", $time);
      end else if (i_rdata !== i_hold) begin
        mismatches++;
        $display("mismatch at time %0t: instruction beat %0d is %h", $time, i_count, i_rdata);
      end
      i_count++;
    end else if (i_count > 0 && i_rdata !== i_hold) begin
      mismatches++;
      $display("mismatch at time %0t: instruction data %h not held", $time, i_rdata);
    end
    if (d_beat_valid) begin
      d_hold = ref_word(cur.d_addr + 32'(d_count * 4));
      if (d_count >= BEATS) begin
        failures++;
        $display("extra data beat at time %0t", $time);
      end else if (d_rdata !== d_hold) begin
        mismatches++;
        $display("mismatch at time %0t: data beat %0d is %h", $time, d_count, d_rdata);
      end
      d_count++;
    end else if (d_count > 0 && d_rdata !== d_hold) begin
      mismatches++;
      $display("mismatch at time %0t: data read %h not held", $time, d_rdata);
    end
    i_end = i_beat_valid && (i_count == BEATS);
    d_end = d_beat_valid && (d_count == BEATS);
  endtask

  task automatic check_ar();
    if (m0_ar_valid && m0_ar_ready && m0_ar !== expect_ar(4'd0, cur.i_addr, 4'd3)) begin
      mismatches++;
      $display("mismatch at time %0t: m0 AR payload %h", $time, m0_ar);
    end
    if (m1_ar_valid && m1_ar_ready && m1_ar !== expect_ar(4'd0, cur.d_addr, 4'd3)) begin
      mismatches++;
      $display("mismatch at time %0t: m1 AR payload %h", $time, m1_ar);
    end
  endtask

  // payload must not move while valid waits for ready
  task automatic check_hold(input int ch, input string name, input logic valid,
                            input logic ready, input logic [44:0] payload);
    if (held_on[ch] && !valid) begin
      failures++;
      $display("%s valid dropped before its handshake at time %0t", name, $time);
    end else if (held_on[ch] && payload !== held_val[ch]) begin
      mismatches++;
      $display("mismatch at time %0t: %s payload changed while stalled", $time, name);
    end
    held_on[ch]  = valid && !ready;
    held_val[ch] = payload;
  endtask

  task automatic track_read(input int m, input logic ar_hs, input logic [31:0] addr,
                            input logic r_ready, input logic r_hs);
    if (rd_on[m] && !r_ready) begin
      failures++;
      $display("master %0d dropped RREADY during a burst at time %0t", m, $time);
    end
    if (r_hs) begin
      rd_beat[m] = rd_beat[m] + 1;
      if (rd_beat[m] == BEATS) begin
        rd_on[m] = 1'b0;
      end
    end
    if (ar_hs) begin
      rd_on[m]   = 1'b1;
      rd_base[m] = addr;
      rd_beat[m] = 0;
    end
  endtask

  task automatic track_write();
    logic [31:0] a;
    if (wr_end && d_busy && !d_req) begin
      mismatches++;
      $display("mismatch at time %0t: d_busy still high after the write response", $time);
    end
    wr_end = m1_b_valid && m1_b_ready;
    if (m1_b_ready && !(aw_got && w_got)) begin
      failures++;
      $display("BREADY rose before AW and W both completed at time %0t", $time);
    end
    if (b_pend && !m1_b_ready) begin
      failures++;
      $display("BREADY dropped while the response was pending at time %0t", $time);
    end
    if (wr_open && !d_busy) begin
      failures++;
      $display("d_busy fell before the write response at time %0t", $time);
    end
    if (m1_aw_valid && m1_aw_ready) begin
      if (m1_aw.id !== 4'd1 || m1_aw.addr !== cur.d_addr || m1_aw.len !== 4'd0 ||
          m1_aw.size !== 3'b010) begin
        mismatches++;
        $display("mismatch at time %0t: m1 AW payload %h", $time, m1_aw);
      end
      aw_got  = 1'b1;
      aw_addr = m1_aw.addr;
    end
    if (m1_w_valid && m1_w_ready) begin
      if (m1_w.data !== cur.wdata || m1_w.strb !== cur.strb || m1_w.last !== 1'b1) begin
        mismatches++;
        $display("mismatch at time %0t: m1 W payload %h, strobe expected %h",
                 $time, m1_w, cur.strb);
      end
      w_got  = 1'b1;
      w_data = m1_w.data;
      w_strb = m1_w.strb;
    end
    if (m1_b_valid && m1_b_ready) begin
      aw_got  = 1'b0;
      w_got   = 1'b0;
      b_pend  = 1'b0;
      wr_open = 1'b0;
    end else if (aw_got && w_got && !b_pend) begin
      a = {aw_addr[31:2], 2'b00};
      slave_mem[a] = merge_bytes(slave_word(a), w_data, w_strb);
      b_pend = 1'b1;
    end
    if (d_req && d_cmd.write) begin
      wr_open = 1'b1;
    end
  endtask

  always @(posedge ACLK) begin
    if (ARESETn) begin
      check_beats();
      check_ar();
      check_hold(0, "m0 AR", m0_ar_valid, m0_ar_ready, m0_ar);
      check_hold(1, "m1 AR", m1_ar_valid, m1_ar_ready, m1_ar);
      check_hold(2, "m1 AW", m1_aw_valid, m1_aw_ready, m1_aw);
      check_hold(3, "m1 W", m1_w_valid, m1_w_ready, {8'b0, m1_w});
      track_write();
      track_read(0, m0_ar_valid && m0_ar_ready, m0_ar.addr, m0_r_ready,
                 m0_r_valid && m0_r_ready);
      track_read(1, m1_ar_valid && m1_ar_ready, m1_ar.addr, m1_r_ready,
                 m1_r_valid && m1_r_ready);
    end
  end

  always @(posedge ACLK) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, a transaction never finished", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // ================================================
  // slave side driven at the falling edge
  // ================================================
  initial begin
    m0_ar_ready = 1'b0;
    m0_r_valid  = 1'b0;
    m0_r        = '0;
    m1_ar_ready = 1'b0;
    m1_r_valid  = 1'b0;
    m1_r        = '0;
    m1_aw_ready = 1'b0;
    m1_w_ready  = 1'b0;
    m1_b_valid  = 1'b0;
    m1_b        = '0;
    forever begin
      @(negedge ACLK);
      m0_ar_ready = ready_draw();
      m1_ar_ready = ready_draw();
      m1_aw_ready = ready_draw();
      m1_w_ready  = ready_draw();
      m0_r_valid  = rd_on[0] && ready_draw();
      m0_r        = read_beat(0);
      m1_r_valid  = rd_on[1] && ready_draw();
      m1_r        = read_beat(1);
      m1_b_valid  = b_pend && ready_draw();
      m1_b        = '{id: 4'd1, resp: axi_pkg::OKAY};
    end
  end

  // ================================================
  // trace replay
  // ================================================
  task automatic load_trace(output logic ok);
    int          fd;
    int          n;
    string       line;
    logic [31:0] v[7];
    trace_t      t;
    ok = 1'b0;
    fd = $fopen(TRACE_PATH, "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
          if (n != 7) begin
            seq_errors++;
            $display("trace line could not be parsed: %s", line);
          end else begin
            t.ports  = v[0][1:0];
            t.i_addr = v[1];
            t.write  = v[2][0];
            t.access = v[3][2:0];
            t.d_addr = v[4];
            t.wdata  = v[5];
            t.strb   = v[6][3:0];
            trace_q.push_back(t);
          end
        end
      end
      $fclose(fd);
      ok = (trace_q.size() != 0);
    end
  endtask

  initial begin
    logic        ok;
    logic [10:0] idle_bits;
    ARESETn = 1'b0;
    i_req   = 1'b0;
    i_addr  = '0;
    d_req   = 1'b0;
    d_cmd   = '0;
    load_trace(ok);
    if (!ok) begin
      $display("trace file %s is missing or empty", TRACE_PATH);
      $display("TEST RESULT: FAIL");
      $finish;
    end else begin
      cycle_limit = trace_q.size() * 60 + 200;
      repeat (4) @(negedge ACLK);
      ARESETn = 1'b1;
      @(negedge ACLK);
      idle_bits = {m0_ar_valid, m0_r_ready, m1_ar_valid, m1_r_ready, m1_aw_valid,
                   m1_w_valid, m1_b_ready, i_busy, d_busy, i_beat_valid, d_beat_valid};
      if (idle_bits !== 11'b0) begin
        seq_errors++;
        $display("mismatch at time %0t: outputs after reset are %b", $time, idle_bits);
      end
      foreach (trace_q[n]) begin
        cur          = trace_q[n];
        i_req        = cur.ports[0];
        i_addr       = cur.i_addr;
        d_req        = cur.ports[1];
        d_cmd.addr   = cur.d_addr;
        d_cmd.wdata  = cur.wdata;
        d_cmd.access = mem_req_pkg::access_e'(cur.access);
        d_cmd.write  = cur.write;
        // expected memory follows the trace strobe
        if (cur.ports[1] && cur.write) begin
          ref_mem[{cur.d_addr[31:2], 2'b00}] = merge_bytes(ref_word(cur.d_addr),
                                                           cur.wdata, cur.strb);
        end
        @(negedge ACLK);
        i_req = 1'b0;
        d_req = 1'b0;
        while (i_busy || d_busy) begin
          @(negedge ACLK);
        end
        if (cur.ports[0] && i_count != BEATS) begin
          seq_errors++;
          $display("mismatch at time %0t: %0d instruction beats seen", $time, i_count);
        end
        if (cur.ports[1] && d_count != (cur.write ? 0 : BEATS)) begin
          seq_errors++;
          $display("mismatch at time %0t: %0d data beats seen", $time, d_count);
        end
      end
      $display("%0d trace lines: %0d bus mismatches, %0d bus failures, %0d sequence errors",
               trace_q.size(), mismatches, failures, seq_errors);
      if (mismatches + failures + seq_errors == 0) begin
        $display("TEST RESULT: PASS");
      end else begin
        $display("TEST RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- cpu_bridge.f
hdl/axi_pkg.sv
hdl/mem_req_pkg.sv
hdl/axi_read_master.sv
hdl/axi_write_master.sv
hdl/data_port_ctrl.sv
hdl/cpu_bridge.sv
testbench/tb_cpu_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the cpu_bridge testbench with Verilator.
# Run from anywhere; paths are taken relative to the project root.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -f cpu_bridge.f --top-module tb_cpu_bridge \
  -Mdir "$OBJ_DIR" -o sim_cpu_bridge > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/sim_cpu_bridge" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" "$SIM_LOG"; then
  exit 1
fi
exit 0

//--- testbench/cpu_bridge_trace.txt
# ports (1 instruction, 2 data, 3 both), i_addr, write, access (0 b, 1 h, 2 w, 4 bu, 5 hu)
# d_addr, write data with bytes in their lanes, expected strobe; all fields hex
1 00001000 0 2 00000000 00000000 0
1 00001040 0 2 00000000 00000000 0
2 00000000 0 2 00002000 00000000 0
2 00000000 1 0 00002000 000000ab 1
2 00000000 1 0 00002001 0000cd00 2
2 00000000 1 4 00002006 00ef0000 4
2 00000000 1 4 00002007 12000000 8
2 00000000 0 2 00002000 00000000 0
2 00000000 1 1 00002010 00003344 3
2 00000000 1 5 00002016 55660000 c
2 00000000 1 1 00002019 00778800 6
2 00000000 0 2 00002010 00000000 0
2 00000000 1 2 00002020 deadbeef f
2 00000000 1 2 00002027 cafef00d f
2 00000000 1 2 0000202c 01234567 f
2 00000000 0 2 00002020 00000000 0
3 00001100 0 2 00002030 00000000 0
3 00001140 1 0 00002042 00990000 4
3 00001180 1 5 00002040 0000aabb 3
3 000011c0 0 2 00002040 00000000 0
3 00001200 0 2 00002200 00000000 0
1 00002010 0 2 00000000 00000000 0
3 00001240 1 2 00002300 76543210 f
3 00001280 0 2 00002300 00000000 0
2 00000000 0 2 00002fc0 00000000 0
1 00008000 0 2 00000000 00000000 0
